// ==== hw/osd_pkg.sv ====
// shared osd command types and constants; the fifo depth must stay a power of two
package osd_pkg;

  // ----------------------------------------
  // plain vectors with a meaning
  typedef logic [7:0]  byte_t;
  typedef logic [2:0]  dat_cnt_t;
  typedef logic [23:0] host_adr_t;
  typedef logic [15:0] host_word_t;

  // top six bits of a command byte
  typedef enum logic [5:0] {
    cmd_nop          = 6'b0_000_00,
    cmd_reset_ctrl   = 6'b0_000_10,
    cmd_osd_ctrl     = 6'b0_010_10,
    cmd_chip_cfg     = 6'b0_000_01,
    cmd_cpu_cfg      = 6'b0_001_01,
    cmd_memory_cfg   = 6'b0_010_01,
    cmd_video_cfg    = 6'b0_011_01,
    cmd_floppy_cfg   = 6'b0_100_01,
    cmd_harddisk_cfg = 6'b0_101_01,
    cmd_joystick_cfg = 6'b0_110_01,
    cmd_mem_write    = 6'b0_001_11,
    cmd_version      = 6'b1_000_10
  } cmd_code_t;

  // ----------------------------------------
  // sizes and reset values
  localparam int fifo_depth = 4;
  localparam int fifo_adr_w = $clog2(fifo_depth);
  // data index stops counting here
  localparam dat_cnt_t dat_cnt_max = 3'd4;
  // byte 0 is the rightmost lane
  localparam logic [3:0][7:0] rtl_version_bytes = {8'd0, 8'd0, 8'd1, 8'd0};
  localparam logic [5:0] memory_cfg_default = 6'b000101;

  // ----------------------------------------
  // bundles between blocks
  typedef struct packed {
    logic  rst;
    logic  osd;
    logic  chipset;
    logic  cpu;
    logic  memory;
    logic  video;
    logic  floppy;
    logic  harddisk;
    logic  joystick;
    byte_t data;
  } cfg_wr_t;

  typedef struct packed {
    logic  start;
    logic  adr0;
    logic  adr1;
    logic  adr2;
    logic  wr;
    byte_t dat;
  } mem_ev_t;

  typedef struct packed {
    logic       osd_enable;
    logic       key_disable;
    logic [1:0] lr_filter;
    logic [1:0] hr_filter;
    logic [1:0] scanline;
    logic [1:0] dither;
    logic [5:0] memory;
    logic [4:0] chipset;
    logic [3:0] floppy;
    logic [3:0] cpu;
    logic [2:0] harddisk;
    logic [1:0] autofire;
    logic       usr_rst;
    logic       cpu_rst;
    logic       cpu_hlt;
  } cfg_out_t;

endpackage

// ==== hw/osd_cmd_decoder.sv ====
// byte_valid must be a one cycle strobe and the byte stream has no back-pressure
`timescale 1ns/1ps

module osd_cmd_decoder import osd_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      byte_valid,
  input  logic      byte_is_cmd,
  input  byte_t     byte_data,
  output cfg_wr_t   cfg_wr,
  output mem_ev_t   mem_ev,
  output cmd_code_t cmd_now,
  output dat_cnt_t  dat_cnt
);

  logic data_stb;
  logic first_stb;
  logic mem_sel;

  // ----------------------------------------
  // command latch and data index
  always_ff @(posedge clk) begin
    if (reset) begin
      cmd_now <= cmd_nop;
      dat_cnt <= '0;
    end else if (byte_valid && byte_is_cmd) begin
      cmd_now <= cmd_code_t'(byte_data[7:2]);
      dat_cnt <= '0;
    end else if (byte_valid && dat_cnt != dat_cnt_max) begin
      // saturates so long bursts keep index 4
      dat_cnt <= dat_cnt + 3'd1;
    end
  end

  assign data_stb  = byte_valid && !byte_is_cmd;
  assign first_stb = data_stb && (dat_cnt == 3'd0);
  assign mem_sel   = (cmd_now == cmd_mem_write);

  // ----------------------------------------
  // register write strobes, first data byte only
  assign cfg_wr.rst      = first_stb && (cmd_now == cmd_reset_ctrl);
  assign cfg_wr.osd      = first_stb && (cmd_now == cmd_osd_ctrl);
  assign cfg_wr.chipset  = first_stb && (cmd_now == cmd_chip_cfg);
  assign cfg_wr.cpu      = first_stb && (cmd_now == cmd_cpu_cfg);
  assign cfg_wr.memory   = first_stb && (cmd_now == cmd_memory_cfg);
  assign cfg_wr.video    = first_stb && (cmd_now == cmd_video_cfg);
  assign cfg_wr.floppy   = first_stb && (cmd_now == cmd_floppy_cfg);
  assign cfg_wr.harddisk = first_stb && (cmd_now == cmd_harddisk_cfg);
  assign cfg_wr.joystick = first_stb && (cmd_now == cmd_joystick_cfg);
  assign cfg_wr.data     = byte_data;

  // ----------------------------------------
  // memory write events
  // new mem write command restarts byte pairing
  assign mem_ev.start = byte_valid && byte_is_cmd && (byte_data[7:2] == cmd_mem_write);
  // address bytes lsb first
  assign mem_ev.adr0  = data_stb && mem_sel && (dat_cnt == 3'd0);
  assign mem_ev.adr1  = data_stb && mem_sel && (dat_cnt == 3'd1);
  assign mem_ev.adr2  = data_stb && mem_sel && (dat_cnt == 3'd2);
  // payload from index 3 on
  assign mem_ev.wr    = data_stb && mem_sel && (dat_cnt >= 3'd3);
  assign mem_ev.dat   = byte_data;

  // regs rely on a single write per data byte
  a_cfg_wr_onehot: assert property (@(posedge clk) disable iff (reset)
    $onehot0({cfg_wr.rst, cfg_wr.osd, cfg_wr.chipset, cfg_wr.cpu, cfg_wr.memory,
              cfg_wr.video, cfg_wr.floppy, cfg_wr.harddisk, cfg_wr.joystick}));

endmodule

// ==== hw/osd_config_regs.sv ====
// staged fields only reach cfg while cpu reset is held high
`timescale 1ns/1ps

module osd_config_regs import osd_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  cfg_wr_t   cfg_wr,
  input  cmd_code_t cmd_now,
  input  dat_cnt_t  dat_cnt,
  input  byte_t     osd_ctrl,
  output cfg_out_t  cfg,
  output byte_t     rd_data
);

  // shadows of staged fields
  logic [5:0] mem_shadow;
  logic [3:0] cpu_shadow;
  logic [2:0] hd_shadow;
  logic       chip_shadow;

  // ----------------------------------------
  // immediate, shadow and reset-control regs
  always_ff @(posedge clk) begin
    if (reset) begin
      cfg         <= '0;
      cfg.memory  <= memory_cfg_default;
      cfg.cpu_rst <= 1'b1;
      cfg.cpu_hlt <= 1'b1;
      mem_shadow  <= memory_cfg_default;
      cpu_shadow  <= '0;
      hd_shadow   <= '0;
      chip_shadow <= 1'b0;
    end else begin
      if (cfg_wr.rst)
        {cfg.cpu_hlt, cfg.cpu_rst, cfg.usr_rst} <= cfg_wr.data[2:0];
      if (cfg_wr.osd)
        {cfg.key_disable, cfg.osd_enable} <= cfg_wr.data[1:0];
      if (cfg_wr.video)
        {cfg.dither, cfg.hr_filter, cfg.lr_filter, cfg.scanline} <= cfg_wr.data;
      if (cfg_wr.floppy)
        cfg.floppy <= cfg_wr.data[3:0];
      if (cfg_wr.joystick)
        cfg.autofire <= cfg_wr.data[1:0];
      // chipset bit 1 is staged, rest immediate
      if (cfg_wr.chipset) begin
        cfg.chipset[4:2] <= cfg_wr.data[4:2];
        cfg.chipset[0]   <= cfg_wr.data[0];
        chip_shadow      <= cfg_wr.data[1];
      end
      if (cfg_wr.memory)
        mem_shadow <= cfg_wr.data[5:0];
      if (cfg_wr.cpu)
        cpu_shadow <= cfg_wr.data[3:0];
      if (cfg_wr.harddisk)
        hd_shadow <= cfg_wr.data[2:0];
      // transfer staged values during cpu reset
      if (cfg.cpu_rst) begin
        cfg.memory     <= mem_shadow;
        cfg.cpu        <= cpu_shadow;
        cfg.harddisk   <= hd_shadow;
        cfg.chipset[1] <= chip_shadow;
      end
    end
  end

  // ----------------------------------------
  // read data
  always_comb begin
    if (cmd_now == cmd_version)
      rd_data = (dat_cnt < 3'd3) ? rtl_version_bytes[dat_cnt[1:0]] : 8'h00;
    else
      rd_data = osd_ctrl;
  end

endmodule

// ==== hw/osd_mem_writer.sv ====
// sender keeps words out while fifo_full is high; an odd trailing byte is never pushed
`timescale 1ns/1ps

module osd_mem_writer import osd_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  mem_ev_t    mem_ev,
  input  logic       fifo_full,
  output logic       push,
  output host_word_t push_word,
  output logic       adr_load,
  output host_adr_t  adr_start
);

  byte_t hi_byte;
  logic  have_hi;

  // ----------------------------------------
  // start address, three bytes lsb first
  always_ff @(posedge clk) begin
    if (mem_ev.adr0)
      adr_start[7:0] <= mem_ev.dat;
    if (mem_ev.adr1)
      adr_start[15:8] <= mem_ev.dat;
    if (mem_ev.adr2)
      adr_start[23:16] <= mem_ev.dat;
  end

  // load pulse once the top byte has landed
  always_ff @(posedge clk) begin
    if (reset)
      adr_load <= 1'b0;
    else
      adr_load <= mem_ev.adr2;
  end

  // ----------------------------------------
  // byte pairing
  always_ff @(posedge clk) begin
    if (reset) begin
      have_hi <= 1'b0;
    end else if (mem_ev.start) begin
      have_hi <= 1'b0;
    end else if (mem_ev.wr) begin
      // toggles each payload byte
      have_hi <= !have_hi;
    end
  end

  // upper half holder
  always_ff @(posedge clk) begin
    if (mem_ev.wr && !have_hi)
      hi_byte <= mem_ev.dat;
  end

  // second byte of a pair completes the word
  assign push      = mem_ev.wr && have_hi;
  assign push_word = {hi_byte, mem_ev.dat};

  // a word pushed while full would be dropped by the fifo
  a_no_push_full: assert property (@(posedge clk) disable iff (reset)
    push |-> !fifo_full);

endmodule

// ==== hw/osd_write_fifo.sv ====
// depth comes from fifo_depth and must be a power of two; no first-word fall-through delay
`timescale 1ns/1ps

module osd_write_fifo import osd_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       push,
  input  host_word_t push_word,
  input  logic       pop,
  output host_word_t head,
  output logic       empty,
  output logic       full
);

  host_word_t            mem [fifo_depth];
  logic [fifo_adr_w-1:0] wr_ptr;
  logic [fifo_adr_w-1:0] rd_ptr;
  logic [fifo_adr_w:0]   count;

  // storage
  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr] <= push_word;
  end

  // ----------------------------------------
  // pointers and occupancy
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // pointers wrap on their own
      if (push)
        wr_ptr <= wr_ptr + fifo_adr_w'(1);
      if (pop)
        rd_ptr <= rd_ptr + fifo_adr_w'(1);
      case ({push, pop})
        2'b10:   count <= count + (fifo_adr_w + 1)'(1);
        2'b01:   count <= count - (fifo_adr_w + 1)'(1);
        default: count <= count;
      endcase
    end
  end

  assign head  = mem[rd_ptr];
  assign empty = (count == '0);
  assign full  = (count == (fifo_adr_w + 1)'(fifo_depth));

  a_no_pop_empty: assert property (@(posedge clk) disable iff (reset) pop |-> !empty);
  a_no_push_full: assert property (@(posedge clk) disable iff (reset) push |-> !full);

endmodule

// ==== hw/osd_host_port.sv ====
// host must complete four-phase req/ack; one word in flight, write only
`timescale 1ns/1ps

module osd_host_port import osd_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       adr_load,
  input  host_adr_t  adr_start,
  input  logic       empty,
  input  host_word_t head,
  input  logic       host_ack,
  output logic       pop,
  output logic       host_cs,
  output logic       host_we,
  output logic [1:0] host_bs,
  output host_adr_t  host_adr,
  output host_word_t host_wdat
);

  typedef enum logic [1:0] {
    st_idle,
    st_req,
    st_release
  } port_state_t;

  port_state_t state;
  host_adr_t   adr_q;

  // ----------------------------------------
  // handshake FSM
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle:    if (!empty) state <= st_req;
        st_req:     if (host_ack) state <= st_release;
        // wait out the ack before next word
        st_release: if (!host_ack) state <= st_idle;
        default:    state <= st_idle;
      endcase
    end
  end

  // word accepted on the ack edge
  assign pop = (state == st_req) && host_ack;

  // address counter, two bytes per word
  always_ff @(posedge clk) begin
    if (reset)
      adr_q <= '0;
    else if (adr_load)
      adr_q <= adr_start;
    else if (pop)
      adr_q <= adr_q + 24'd2;
  end

  // ----------------------------------------
  // host bus
  assign host_cs   = (state == st_req);
  assign host_we   = host_cs;
  assign host_bs   = {2{host_cs}};
  assign host_adr  = adr_q;
  assign host_wdat = head;

  // request held until the host answers
  a_cs_until_ack: assert property (@(posedge clk) disable iff (reset)
    host_cs && !host_ack |=> host_cs);

endmodule

// ==== hw/userio_osd.sv ====
// command side only; byte stream arrives framed and host_rdat is not used
`timescale 1ns/1ps

module userio_osd import osd_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       byte_valid,
  input  logic       byte_is_cmd,
  input  byte_t      byte_data,
  input  byte_t      osd_ctrl,
  input  host_word_t host_rdat,
  input  logic       host_ack,
  output byte_t      rd_data,
  output cfg_out_t   cfg,
  output logic       fifo_full,
  output logic       host_cs,
  output logic       host_we,
  output logic [1:0] host_bs,
  output host_adr_t  host_adr,
  output host_word_t host_wdat
);

  // decoder outputs
  cfg_wr_t    cfg_wr;
  mem_ev_t    mem_ev;
  cmd_code_t  cmd_now;
  dat_cnt_t   dat_cnt;

  // memory path links
  logic       push;
  host_word_t push_word;
  logic       adr_load;
  host_adr_t  adr_start;
  logic       pop;
  host_word_t head;
  logic       empty;

  // ----------------------------------------
  // byte side
  osd_cmd_decoder u_decoder (
    .clk(clk),
    .reset(reset),
    .byte_valid(byte_valid),
    .byte_is_cmd(byte_is_cmd),
    .byte_data(byte_data),
    .cfg_wr(cfg_wr),
    .mem_ev(mem_ev),
    .cmd_now(cmd_now),
    .dat_cnt(dat_cnt)
  );

  osd_config_regs u_regs (
    .clk(clk),
    .reset(reset),
    .cfg_wr(cfg_wr),
    .cmd_now(cmd_now),
    .dat_cnt(dat_cnt),
    .osd_ctrl(osd_ctrl),
    .cfg(cfg),
    .rd_data(rd_data)
  );

  // ----------------------------------------
  // memory write path
  osd_mem_writer u_mem_writer (
    .clk(clk),
    .reset(reset),
    .mem_ev(mem_ev),
    .fifo_full(fifo_full),
    .push(push),
    .push_word(push_word),
    .adr_load(adr_load),
    .adr_start(adr_start)
  );

  osd_write_fifo u_fifo (
    .clk(clk),
    .reset(reset),
    .push(push),
    .push_word(push_word),
    .pop(pop),
    .head(head),
    .empty(empty),
    .full(fifo_full)
  );

  osd_host_port u_host_port (
    .clk(clk),
    .reset(reset),
    .adr_load(adr_load),
    .adr_start(adr_start),
    .empty(empty),
    .head(head),
    .host_ack(host_ack),
    .pop(pop),
    .host_cs(host_cs),
    .host_we(host_we),
    .host_bs(host_bs),
    .host_adr(host_adr),
    .host_wdat(host_wdat)
  );

endmodule

// ==== tests/tb_userio_osd.sv ====
// host responder answers writes only and draws its ack delays from a fixed-seed lcg
`timescale 1ns/1ps

module tb_userio_osd import osd_pkg::*; ();

  // all waits at their limits stay under 6000 cycles
  localparam int cycle_limit = 20000;
  localparam int wait_limit  = 200;

  logic       clk;
  logic       reset;
  logic       byte_valid;
  logic       byte_is_cmd;
  byte_t      byte_data;
  byte_t      osd_ctrl;
  host_word_t host_rdat;
  logic       host_ack;
  byte_t      rd_data;
  cfg_out_t   cfg;
  logic       fifo_full;
  logic       host_cs;
  logic       host_we;
  logic [1:0] host_bs;
  host_adr_t  host_adr;
  host_word_t host_wdat;

  int          err_count;
  int          other_count;
  int          cycle_count;
  int unsigned rng_state = 32'd5927;
  bit          slow_host;
  cfg_out_t    exp_cfg;
  host_adr_t   rec_adr[$];
  host_word_t  rec_dat[$];
  host_word_t  exp_words[$];

  userio_osd dut (
    .clk(clk),
    .reset(reset),
    .byte_valid(byte_valid),
    .byte_is_cmd(byte_is_cmd),
    .byte_data(byte_data),
    .osd_ctrl(osd_ctrl),
    .host_rdat(host_rdat),
    .host_ack(host_ack),
    .rd_data(rd_data),
    .cfg(cfg),
    .fifo_full(fifo_full),
    .host_cs(host_cs),
    .host_we(host_we),
    .host_bs(host_bs),
    .host_adr(host_adr),
    .host_wdat(host_wdat)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // run limit
  initial begin
    cycle_count = 0;
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
    $display("Result: FAILED");
    $finish;
  end

  function automatic int unsigned lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state >> 16;
  endfunction

  // ----------------------------------------
  // host memory model, four-phase req/ack
  initial begin : host_responder
    int delay;
    forever begin
      @(posedge clk);
      #1;
      if (host_cs && !host_ack) begin
        delay = slow_host ? 4 : 1 + int'(lcg_next() % 4);
        repeat (delay - 1) begin
          @(posedge clk);
          #1;
        end
        if (host_we !== 1'b1 || host_bs !== 2'b11) begin
          other_count++;
          $display("host request at %0t ns without write enable and both byte selects", $time);
        end
        host_ack = 1'b1;
        rec_adr.push_back(host_adr);
        rec_dat.push_back(host_wdat);
        // hold ack until the port drops its request
        do begin
          @(posedge clk);
          #1;
        end while (host_cs);
        host_ack = 1'b0;
      end
    end
  end

  // ----------------------------------------
  // byte side drivers, entered 1 ns after an edge
  task automatic tick(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic send_cmd(input cmd_code_t code);
    byte_is_cmd = 1'b1;
    byte_data   = {code, 2'b00};
    byte_valid  = 1'b1;
    tick(1);
    byte_valid  = 1'b0;
    byte_is_cmd = 1'b0;
  endtask

  task automatic send_data(input byte_t b);
    byte_is_cmd = 1'b0;
    byte_data   = b;
    byte_valid  = 1'b1;
    tick(1);
    byte_valid  = 1'b0;
  endtask

  task automatic write_reg(input cmd_code_t code, input byte_t b);
    send_cmd(code);
    send_data(b);
  endtask

  // second byte completes the word, so it waits for room
  task automatic send_word(input host_word_t w);
    int waited;
    waited = 0;
    send_data(w[15:8]);
    while (fifo_full && waited < wait_limit) begin
      tick(1);
      waited++;
    end
    if (fifo_full) begin
      other_count++;
      $display("write fifo stayed full, word %04h was not sent", w);
    end else begin
      send_data(w[7:0]);
      exp_words.push_back(w);
    end
  endtask

  // ----------------------------------------
  // compare tasks
  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp) begin
      err_count++;
      $display("CHECK FAILED at %0t ns: %s is %02h, expected %02h", $time, name, got, exp);
    end
  endtask

  task automatic check_cfg(input string name, input cfg_out_t got, input cfg_out_t exp);
    if (got !== exp) begin
      err_count++;
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_adr(input string name, input host_adr_t got, input host_adr_t exp);
    if (got !== exp) begin
      err_count++;
      $display("CHECK FAILED at %0t ns: %s is %06h, expected %06h", $time, name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input host_word_t got, input host_word_t exp);
    if (got !== exp) begin
      err_count++;
      $display("CHECK FAILED at %0t ns: %s is %04h, expected %04h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      err_count++;
      $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  // waits for every expected write, then compares address and data in order
  task automatic check_host_writes(input host_adr_t base);
    int waited;
    waited = 0;
    while ((rec_adr.size() < exp_words.size() || host_ack) && waited < 4 * wait_limit) begin
      tick(1);
      waited++;
    end
    if (rec_adr.size() != exp_words.size()) begin
      other_count++;
      $display("host saw %0d writes where %0d were sent", rec_adr.size(), exp_words.size());
    end
    for (int i = 0; i < exp_words.size() && i < rec_adr.size(); i++) begin
      check_adr("host_adr", rec_adr[i], base + host_adr_t'(2 * i));
      check_word("host_wdat", rec_dat[i], exp_words[i]);
    end
    rec_adr.delete();
    rec_dat.delete();
    exp_words.delete();
  endtask

  // ----------------------------------------
  // directed tests
  task automatic test_after_reset();
    exp_cfg         = '0;
    exp_cfg.memory  = memory_cfg_default;
    exp_cfg.cpu_rst = 1'b1;
    exp_cfg.cpu_hlt = 1'b1;
    check_cfg("cfg after reset", cfg, exp_cfg);
    check_flag("host_cs", host_cs, 1'b0);
    check_flag("fifo_full", fifo_full, 1'b0);
  endtask

  task automatic test_immediate();
    // release cpu reset so staged fields hold still
    write_reg(cmd_reset_ctrl, 8'h00);
    exp_cfg.cpu_rst = 1'b0;
    exp_cfg.cpu_hlt = 1'b0;
    check_cfg("cfg after reset control", cfg, exp_cfg);
    write_reg(cmd_osd_ctrl, 8'h03);
    exp_cfg.osd_enable  = 1'b1;
    exp_cfg.key_disable = 1'b1;
    check_cfg("cfg after osd write", cfg, exp_cfg);
    // later data bytes are ignored
    send_data(8'h00);
    check_cfg("cfg after extra osd byte", cfg, exp_cfg);
    write_reg(cmd_video_cfg, 8'hb4);
    exp_cfg.dither    = 2'b10;
    exp_cfg.hr_filter = 2'b11;
    exp_cfg.lr_filter = 2'b01;
    exp_cfg.scanline  = 2'b00;
    check_cfg("cfg after video write", cfg, exp_cfg);
    write_reg(cmd_floppy_cfg, 8'h0a);
    send_data(8'h05);
    exp_cfg.floppy = 4'ha;
    check_cfg("cfg after floppy write", cfg, exp_cfg);
    write_reg(cmd_joystick_cfg, 8'h02);
    exp_cfg.autofire = 2'b10;
    check_cfg("cfg after joystick write", cfg, exp_cfg);
    // bit 1 is staged and stays 0 here
    write_reg(cmd_chip_cfg, 8'h1f);
    exp_cfg.chipset = 5'b11101;
    check_cfg("cfg after chipset write", cfg, exp_cfg);
  endtask

  task automatic test_staged();
    write_reg(cmd_memory_cfg, 8'h2a);
    write_reg(cmd_cpu_cfg, 8'h07);
    write_reg(cmd_harddisk_cfg, 8'h05);
    tick(3);
    check_cfg("cfg staged while cpu runs", cfg, exp_cfg);
    write_reg(cmd_reset_ctrl, 8'h02);
    exp_cfg.cpu_rst = 1'b1;
    check_cfg("cfg as cpu reset rises", cfg, exp_cfg);
    // copy lands one cycle later
    tick(1);
    exp_cfg.memory     = 6'h2a;
    exp_cfg.cpu        = 4'h7;
    exp_cfg.harddisk   = 3'h5;
    exp_cfg.chipset[1] = 1'b1;
    check_cfg("cfg during cpu reset", cfg, exp_cfg);
    write_reg(cmd_reset_ctrl, 8'h00);
    exp_cfg.cpu_rst = 1'b0;
    check_cfg("cfg after cpu reset release", cfg, exp_cfg);
  endtask

  task automatic test_read_data();
    byte_t ver[5];
    ver = '{8'h00, 8'h01, 8'h00, 8'h00, 8'h00};
    send_cmd(cmd_version);
    check_byte("rd_data version 0", rd_data, ver[0]);
    for (int i = 1; i < 5; i++) begin
      send_data(8'hff);
      check_byte("rd_data version", rd_data, ver[i]);
    end
    send_cmd(cmd_osd_ctrl);
    osd_ctrl = 8'h5a;
    tick(1);
    check_byte("rd_data keyboard code", rd_data, 8'h5a);
    osd_ctrl = 8'hc3;
    tick(1);
    check_byte("rd_data keyboard code", rd_data, 8'hc3);
    check_cfg("cfg after reads", cfg, exp_cfg);
  endtask

  task automatic start_session(input host_adr_t a);
    send_cmd(cmd_mem_write);
    send_data(a[7:0]);
    send_data(a[15:8]);
    send_data(a[23:16]);
  endtask

  task automatic test_mem_write();
    slow_host = 1'b0;
    start_session(24'h012344);
    for (int i = 0; i < 3; i++)
      send_word(host_word_t'(lcg_next()));
    check_host_writes(24'h012344);
  endtask

  task automatic test_slow_host();
    int waited;
    int sent;
    slow_host = 1'b1;
    sent      = 0;
    start_session(24'h008000);
    while (!fifo_full && sent < 3 * fifo_depth) begin
      send_word(16'ha000 + host_word_t'(sent));
      sent++;
    end
    if (!fifo_full) begin
      other_count++;
      $display("fifo_full never rose while %0d words went to a slow host", sent);
    end
    waited = 0;
    while (fifo_full && waited < wait_limit) begin
      tick(1);
      waited++;
    end
    if (fifo_full) begin
      other_count++;
      $display("fifo_full never fell while the slow host drained words");
    end
    send_word(16'hb000);
    send_word(16'hb001);
    check_host_writes(24'h008000);
    slow_host = 1'b0;
  endtask

  // ----------------------------------------
  // main sequence
  initial begin
    err_count   = 0;
    other_count = 0;
    slow_host   = 1'b0;
    reset       = 1'b1;
    byte_valid  = 1'b0;
    byte_is_cmd = 1'b0;
    byte_data   = '0;
    osd_ctrl    = '0;
    host_rdat   = '0;
    host_ack    = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    test_after_reset();
    test_immediate();
    test_staged();
    test_read_data();
    test_mem_write();
    test_slow_host();
    tick(4);
    $display("errors: %0d value mismatches, %0d other failures", err_count, other_count);
    if (err_count == 0 && other_count == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

// ==== filelist.f ====
hw/osd_pkg.sv
hw/osd_cmd_decoder.sv
hw/osd_config_regs.sv
hw/osd_mem_writer.sv
hw/osd_write_fifo.sv
hw/osd_host_port.sv
hw/userio_osd.sv
tests/tb_userio_osd.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_userio_osd
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Result: FAILED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail on a failed run"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
